// File: logic/core_cfg_pkg.sv
// core widths and memory map; reset_pc and the mapped addresses are only defaults for core_top
`default_nettype none

package core_cfg_pkg;

    localparam int data_width    = 32;
    localparam int addr_width    = 32;
    localparam int num_regs      = 32;
    localparam int reg_sel_width = 5;

    typedef logic [data_width-1:0]    word_t;
    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [reg_sel_width-1:0] reg_sel_t;

    // first fetch address
    localparam addr_t reset_pc = '0;

    // stores here never reach memory
    localparam addr_t out_port_addr = addr_t'(1000);
    localparam addr_t halt_addr     = addr_t'(1004);

    typedef enum logic [1:0] {
        FETCH,
        WAIT_INSTR,
        WAIT_MEM,
        HALTED
    } ctl_state_t;

endpackage

`default_nettype wire

// File: logic/rv_isa_pkg.sv
// RV32I encodings for the subset this core runs; RV32M and other opcodes are not listed
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // funct7 in the upper bits, funct3 in the lower bits
    typedef logic [$bits(funct7_t)+$bits(funct3_t)-1:0] alu_funct_t;

    localparam opcode_t op_opimm  = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;

    localparam funct3_t f3_addi = 3'b000;
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;

    localparam alu_funct_t fn_add  = {7'b0000000, 3'b000};
    localparam alu_funct_t fn_sub  = {7'b0100000, 3'b000};
    localparam alu_funct_t fn_sll  = {7'b0000000, 3'b001};
    localparam alu_funct_t fn_slt  = {7'b0000000, 3'b010};
    localparam alu_funct_t fn_sltu = {7'b0000000, 3'b011};
    localparam alu_funct_t fn_xor  = {7'b0000000, 3'b100};
    localparam alu_funct_t fn_srl  = {7'b0000000, 3'b101};
    localparam alu_funct_t fn_sra  = {7'b0100000, 3'b101};
    localparam alu_funct_t fn_or   = {7'b0000000, 3'b110};
    localparam alu_funct_t fn_and  = {7'b0000000, 3'b111};

endpackage

`default_nettype wire

// File: logic/regfile_if.sv
// register file port bundle; reads are combinational, writes land on the clock edge
`timescale 1ns/1ns
`default_nettype none

interface regfile_if;
    import core_cfg_pkg::*;

    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    word_t    rs1_data;
    word_t    rs2_data;
    reg_sel_t wr_sel;
    word_t    wr_data;
    logic     wr_en;

    modport owner (input rs1_sel, rs2_sel, wr_sel, wr_data, wr_en, output rs1_data, rs2_data);

    modport user (output rs1_sel, rs2_sel, wr_sel, wr_data, wr_en, input rs1_data, rs2_data);

endinterface

`default_nettype wire

// File: logic/instr_decoder.sv
// purely combinational field split; fields are valid for any word, legal or not
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire rv_isa_pkg::instr_t      instr,
    output rv_isa_pkg::opcode_t          opcode,
    output rv_isa_pkg::funct3_t          funct3,
    output rv_isa_pkg::alu_funct_t       alu_funct,
    output core_cfg_pkg::reg_sel_t       rd,
    output core_cfg_pkg::reg_sel_t       rs1,
    output core_cfg_pkg::reg_sel_t       rs2,
    output core_cfg_pkg::word_t          imm_i,
    output core_cfg_pkg::word_t          imm_s,
    output core_cfg_pkg::word_t          imm_b,
    output core_cfg_pkg::word_t          imm_u
);
    import core_cfg_pkg::*;

    assign opcode    = instr[6:0];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign alu_funct = {instr[31:25], instr[14:12]};

    assign imm_i = {{(data_width-12){instr[31]}}, instr[31:20]};

    // S type splits the offset around rd
    assign imm_s = {{(data_width-12){instr[31]}}, instr[31:25], instr[11:7]};

    // B type offset in bytes, bit 0 always zero
    assign imm_b = {{(data_width-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    assign imm_u = {instr[31:12], 12'b0};

endmodule

`default_nettype wire

// File: logic/alu.sv
// combinational datapath for OP, ADDI, branch compare and load/store address; no overflow flags
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire rv_isa_pkg::alu_funct_t  alu_funct,
    input  wire rv_isa_pkg::funct3_t     funct3,
    input  wire rv_isa_pkg::opcode_t     opcode,
    input  wire core_cfg_pkg::word_t     rs1_data,
    input  wire core_cfg_pkg::word_t     rs2_data,
    input  wire core_cfg_pkg::word_t     imm_i,
    input  wire core_cfg_pkg::word_t     imm_s,
    output core_cfg_pkg::word_t          result,
    output core_cfg_pkg::addr_t          eff_addr,
    output logic                         take_branch
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int shamt_width = $clog2(data_width);

    logic [shamt_width-1:0] shamt;
    logic                   operands_equal;

    assign shamt          = rs2_data[shamt_width-1:0];
    assign operands_equal = (rs1_data == rs2_data);

    always_comb begin
        result = '0;
        if (opcode == op_opimm) begin
            result = rs1_data + imm_i;
        end else if (opcode == op_op) begin
            case (alu_funct)
                fn_add:  result = rs1_data + rs2_data;
                fn_sub:  result = rs1_data - rs2_data;
                fn_slt:  result = word_t'($signed(rs1_data) < $signed(rs2_data));
                fn_sltu: result = word_t'(rs1_data < rs2_data);
                fn_and:  result = rs1_data & rs2_data;
                fn_or:   result = rs1_data | rs2_data;
                fn_xor:  result = rs1_data ^ rs2_data;
                fn_sll:  result = rs1_data << shamt;
                fn_srl:  result = rs1_data >> shamt;
                fn_sra:  result = word_t'($signed(rs1_data) >>> shamt);
                default: result = '0;
            endcase
        end
    end

    // stores use the split S immediate, loads the I immediate
    assign eff_addr = (opcode == op_store) ? rs1_data + imm_s : rs1_data + imm_i;

    assign take_branch = (opcode == op_branch) &&
                         (((funct3 == f3_beq) && operands_equal) ||
                          ((funct3 == f3_bne) && !operands_equal));

endmodule

`default_nettype wire

// File: logic/register_file.sv
// 32 x 32 registers with async reset to zero; x0 is hardwired and drops writes
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire      clk,
    input  wire      rst,
    regfile_if.owner rf
);
    import core_cfg_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && (rf.wr_sel != '0)) begin
            regs[rf.wr_sel] <= rf.wr_data;
        end
    end

    // x0 forced on the read side as well
    assign rf.rs1_data = (rf.rs1_sel == '0) ? '0 : regs[rf.rs1_sel];
    assign rf.rs2_data = (rf.rs2_sel == '0) ? '0 : regs[rf.rs2_sel];

endmodule

`default_nettype wire

// File: logic/core_control.sv
// multi-cycle control; memory must latch a request pulse and ack it one or more cycles later
`timescale 1ns/1ns
`default_nettype none

module core_control #(
    parameter core_cfg_pkg::addr_t reset_pc      = core_cfg_pkg::reset_pc,
    parameter core_cfg_pkg::addr_t out_port_addr = core_cfg_pkg::out_port_addr,
    parameter core_cfg_pkg::addr_t halt_addr     = core_cfg_pkg::halt_addr
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire core_cfg_pkg::word_t mem_rd_data,
    input  wire                  mem_ack,
    output core_cfg_pkg::addr_t  mem_addr,
    output core_cfg_pkg::word_t  mem_wr_data,
    output logic                 mem_rd_req,
    output logic                 mem_wr_req,
    output core_cfg_pkg::word_t  out,
    output logic                 outen,
    output logic                 halt,
    output core_cfg_pkg::addr_t  pc,
    regfile_if.user              rf
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    ctl_state_t state;
    ctl_state_t next_state;
    addr_t      next_pc;
    reg_sel_t   load_rd;
    reg_sel_t   next_load_rd;

    opcode_t    opcode;
    funct3_t    funct3;
    alu_funct_t alu_funct;
    reg_sel_t   rd;
    reg_sel_t   rs1;
    reg_sel_t   rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      alu_result;
    addr_t      eff_addr;
    logic       take_branch;

    // instruction word is only meaningful in the WAIT_INSTR ack cycle
    instr_decoder u_decoder (
        .instr     (mem_rd_data),
        .opcode    (opcode),
        .funct3    (funct3),
        .alu_funct (alu_funct),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm_i     (imm_i),
        .imm_s     (imm_s),
        .imm_b     (imm_b),
        .imm_u     (imm_u)
    );

    alu u_alu (
        .alu_funct   (alu_funct),
        .funct3      (funct3),
        .opcode      (opcode),
        .rs1_data    (rf.rs1_data),
        .rs2_data    (rf.rs2_data),
        .imm_i       (imm_i),
        .imm_s       (imm_s),
        .result      (alu_result),
        .eff_addr    (eff_addr),
        .take_branch (take_branch)
    );

    assign rf.rs1_sel = rs1;
    assign rf.rs2_sel = rs2;

    always_comb begin
        logic  fetch_next;
        addr_t fetch_pc;

        fetch_next   = 1'b0;
        fetch_pc     = pc + addr_t'(4);
        next_state   = state;
        next_pc      = pc;
        next_load_rd = load_rd;
        mem_addr     = '0;
        mem_wr_data  = '0;
        mem_rd_req   = 1'b0;
        mem_wr_req   = 1'b0;
        out          = '0;
        outen        = 1'b0;
        halt         = 1'b0;
        rf.wr_sel    = rd;
        rf.wr_data   = alu_result;
        rf.wr_en     = 1'b0;

        case (state)
            FETCH: begin
                // no request while reset is held
                if (!rst) begin
                    mem_addr   = pc;
                    mem_rd_req = 1'b1;
                    next_state = WAIT_INSTR;
                end
            end
            WAIT_INSTR: begin
                if (mem_ack) begin
                    case (opcode)
                        op_op: begin
                            rf.wr_en   = 1'b1;
                            fetch_next = 1'b1;
                        end
                        op_opimm: begin
                            if (funct3 == f3_addi) begin
                                rf.wr_en   = 1'b1;
                                fetch_next = 1'b1;
                            end else begin
                                next_state = HALTED;
                            end
                        end
                        op_lui: begin
                            rf.wr_data = imm_u;
                            rf.wr_en   = 1'b1;
                            fetch_next = 1'b1;
                        end
                        op_auipc: begin
                            // pc still points at this instruction
                            rf.wr_data = pc + imm_u;
                            rf.wr_en   = 1'b1;
                            fetch_next = 1'b1;
                        end
                        op_branch: begin
                            if (take_branch) begin
                                fetch_pc = pc + imm_b;
                            end
                            fetch_next = 1'b1;
                        end
                        op_load: begin
                            mem_addr     = eff_addr;
                            mem_rd_req   = 1'b1;
                            next_load_rd = rd;
                            next_state   = WAIT_MEM;
                        end
                        op_store: begin
                            if (eff_addr == out_port_addr) begin
                                out        = rf.rs2_data;
                                outen      = 1'b1;
                                fetch_next = 1'b1;
                            end else if (eff_addr == halt_addr) begin
                                next_state = HALTED;
                            end else begin
                                mem_addr     = eff_addr;
                                mem_wr_data  = rf.rs2_data;
                                mem_wr_req   = 1'b1;
                                // x0 target drops the writeback on ack
                                next_load_rd = '0;
                                next_state   = WAIT_MEM;
                            end
                        end
                        default: next_state = HALTED;
                    endcase
                end
            end
            WAIT_MEM: begin
                if (mem_ack) begin
                    rf.wr_sel  = load_rd;
                    rf.wr_data = mem_rd_data;
                    rf.wr_en   = 1'b1;
                    fetch_next = 1'b1;
                end
            end
            HALTED: begin
                halt = 1'b1;
            end
            default: next_state = HALTED;
        endcase

        // next fetch goes out in the same cycle the instruction retires
        if (fetch_next) begin
            next_pc    = fetch_pc;
            mem_addr   = fetch_pc;
            mem_rd_req = 1'b1;
            next_state = WAIT_INSTR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= FETCH;
            pc      <= reset_pc;
            load_rd <= '0;
        end else begin
            state   <= next_state;
            pc      <= next_pc;
            load_rd <= next_load_rd;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_top.sv
// core without memory; the external memory sees pulse requests and answers with one ack each
`timescale 1ns/1ns
`default_nettype none

module core_top #(
    parameter core_cfg_pkg::addr_t reset_pc      = core_cfg_pkg::reset_pc,
    parameter core_cfg_pkg::addr_t out_port_addr = core_cfg_pkg::out_port_addr,
    parameter core_cfg_pkg::addr_t halt_addr     = core_cfg_pkg::halt_addr
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire core_cfg_pkg::word_t  mem_rd_data,
    input  wire                       mem_ack,
    output wire core_cfg_pkg::addr_t  mem_addr,
    output wire core_cfg_pkg::word_t  mem_wr_data,
    output wire                       mem_rd_req,
    output wire                       mem_wr_req,
    output wire core_cfg_pkg::word_t  out,
    output wire                       outen,
    output wire                       halt,
    output wire core_cfg_pkg::addr_t  pc
);

    regfile_if rf ();

    register_file u_regfile (
        .clk (clk),
        .rst (rst),
        .rf  (rf.owner)
    );

    core_control #(
        .reset_pc      (reset_pc),
        .out_port_addr (out_port_addr),
        .halt_addr     (halt_addr)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out         (out),
        .outen       (outen),
        .halt        (halt),
        .pc          (pc),
        .rf          (rf.user)
    );

endmodule

`default_nettype wire

// File: test/core_checker.sv
// samples on the falling edge; expects one out value per outen pulse, in the order they were added
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input wire                       clk,
    input wire                       rst,
    input wire core_cfg_pkg::word_t  out,
    input wire                       outen,
    input wire                       halt,
    input wire                       mem_rd_req,
    input wire                       mem_wr_req,
    input wire core_cfg_pkg::addr_t  pc,
    input wire core_cfg_pkg::word_t  data_word
);
    import core_cfg_pkg::*;

    word_t expected [$];
    int    next_idx     = 0;
    int    outen_count  = 0;
    int    value_errors = 0;
    int    other_errors = 0;
    logic  halt_seen    = 1'b0;

    task automatic add_expected(input word_t value);
        expected.push_back(value);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (mem_rd_req !== 1'b0 || mem_wr_req !== 1'b0 || outen !== 1'b0 ||
                halt !== 1'b0) begin
                $display("core drives a request, outen or halt during reset at %0t", $time);
                other_errors++;
            end
        end else begin
            if (halt_seen && halt !== 1'b1) begin
                $display("halt dropped after it was raised at %0t", $time);
                other_errors++;
            end
            if (halt_seen && (mem_rd_req !== 1'b0 || mem_wr_req !== 1'b0)) begin
                $display("memory request after halt at %0t", $time);
                other_errors++;
            end
            if (outen === 1'b1) begin
                outen_count++;
                if (halt_seen) begin
                    $display("outen pulse after halt at %0t", $time);
                    other_errors++;
                end else if (next_idx >= expected.size()) begin
                    $display("more outen pulses than expected values at %0t", $time);
                    other_errors++;
                end else begin
                    if (out !== expected[next_idx]) begin
                        $display("FAIL %0t: output %0d is %h, expected %h",
                                 $time, next_idx, out, expected[next_idx]);
                        value_errors++;
                    end
                    next_idx++;
                end
            end
            if (halt === 1'b1) begin
                halt_seen = 1'b1;
            end
        end
    end

    // called once the quiet window after halt has passed
    task automatic finish_checks(input word_t stored_expect, input addr_t halt_pc_expect);
        if (pc !== halt_pc_expect) begin
            $display("FAIL %0t: pc at halt is %h, expected %h",
                     $time, pc, halt_pc_expect);
            value_errors++;
        end
        if (outen_count != expected.size()) begin
            $display("saw %0d outen pulses for %0d expected values",
                     outen_count, expected.size());
            other_errors++;
        end
        if (data_word !== stored_expect) begin
            $display("FAIL %0t: data memory word is %h, expected %h",
                     $time, data_word, stored_expect);
            value_errors++;
        end
    endtask

endmodule

`default_nettype wire

// File: test/tb_core.sv
// program runs from prog_base with data at address 64; memory answers each request in 1 to 3 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_core;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam addr_t       prog_base = addr_t'('h100);
    localparam addr_t       data_addr = addr_t'(64);
    localparam logic [11:0] out_off   = 12'(out_port_addr);
    localparam logic [11:0] halt_off  = 12'(halt_addr);
    localparam int          mem_words = 256;
    localparam int          num_rows  = 12;

    logic  clk         = 1'b0;
    logic  rst         = 1'b1;
    word_t mem_rd_data = '0;
    logic  mem_ack     = 1'b0;
    addr_t mem_addr;
    word_t mem_wr_data;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t out;
    logic  outen;
    logic  halt;
    addr_t pc;

    word_t       mem [mem_words];
    instr_t      prog [$];
    logic [65:0] alu_rows [num_rows];
    int          num_expected  = 0;
    int          cycle_count   = 0;
    int          timeout_limit = 0;

    // memory model request state
    logic        busy      = 1'b0;
    logic        req_wr    = 1'b0;
    addr_t       req_addr  = '0;
    int          wait_cnt  = 0;
    int unsigned lcg_state = 50;

    core_top #(
        .reset_pc      (prog_base),
        .out_port_addr (out_port_addr),
        .halt_addr     (halt_addr)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out         (out),
        .outen       (outen),
        .halt        (halt),
        .pc          (pc)
    );

    core_checker chk (
        .clk        (clk),
        .rst        (rst),
        .out        (out),
        .outen      (outen),
        .halt       (halt),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .pc         (pc),
        .data_word  (mem[data_addr[9:2]])
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic instr_t imm_instr(input logic [11:0] imm, input reg_sel_t rs1,
                                         input funct3_t f3, input reg_sel_t rd,
                                         input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t reg_instr(input alu_funct_t fn, input reg_sel_t rs2,
                                         input reg_sel_t rs1, input reg_sel_t rd);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, op_op};
    endfunction

    function automatic instr_t store_instr(input logic [11:0] imm, input reg_sel_t rs2,
                                           input reg_sel_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    // offset in bytes with bit 0 dropped by the encoding
    function automatic instr_t branch_instr(input logic [12:0] imm, input reg_sel_t rs2,
                                            input reg_sel_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic instr_t upper_instr(input logic [19:0] imm, input reg_sel_t rd,
                                           input opcode_t op);
        return {imm, rd, op};
    endfunction

    task automatic emit(input instr_t word);
        prog.push_back(word);
    endtask

    task automatic expect_out(input word_t value);
        chk.add_expected(value);
        num_expected++;
    endtask

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout, core did not halt within %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // latches one request, acks it after a pseudo random delay
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (busy) begin
            if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                busy    <= 1'b0;
                mem_ack <= 1'b1;
                if (!req_wr) begin
                    mem_rd_data <= mem[req_addr[9:2]];
                end
            end
        end else if (mem_rd_req === 1'b1 || mem_wr_req === 1'b1) begin
            busy     <= 1'b1;
            req_addr <= mem_addr;
            req_wr   <= mem_wr_req;
            if (mem_wr_req === 1'b1) begin
                mem[mem_addr[9:2]] <= mem_wr_data;
            end
            lcg_state = lcg_next(lcg_state);
            wait_cnt <= 1 + int'((lcg_state >> 16) % 3);
        end
    end

    initial begin
        addr_t auipc_pc;
        addr_t halt_pc;

        // unused words decode as an unknown opcode
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (word_t'(i) << 7) | word_t'(7'h7f);
        end

        // operand a, operand b (both sign extended by ADDI), ALU code, expected result
        alu_rows = '{
            {12'd100, 12'd23,  fn_add,  32'd123},
            {12'd5,   12'd12,  fn_sub,  32'hffff_fff9},
            {12'hffd, 12'd2,   fn_slt,  32'd1},
            {12'hffd, 12'd2,   fn_sltu, 32'd0},
            {12'd7,   12'hfff, fn_slt,  32'd0},
            {12'h6a5, 12'h3c3, fn_and,  32'h0000_0281},
            {12'h6a5, 12'h3c3, fn_or,   32'h0000_07e7},
            {12'hfff, 12'h555, fn_xor,  32'hffff_faaa},
            {12'd3,   12'd4,   fn_sll,  32'h0000_0030},
            {12'hff0, 12'd4,   fn_srl,  32'h0fff_ffff},
            {12'hf00, 12'd4,   fn_sra,  32'hffff_fff0},
            {12'd1,   12'd33,  fn_sll,  32'h0000_0002}
        };

        for (int r = 0; r < num_rows; r++) begin
            emit(imm_instr(alu_rows[r][65:54], 5'd0, f3_addi, 5'd1, op_opimm));
            emit(imm_instr(alu_rows[r][53:42], 5'd0, f3_addi, 5'd2, op_opimm));
            emit(reg_instr(alu_rows[r][41:32], 5'd2, 5'd1, 5'd3));
            emit(store_instr(out_off, 5'd3, 5'd0));
            expect_out(alu_rows[r][31:0]);
        end

        // round trip through data memory
        emit(imm_instr(12'h5a5, 5'd0, f3_addi, 5'd4, op_opimm));
        emit(store_instr(12'(data_addr), 5'd4, 5'd0));
        emit(imm_instr(12'(data_addr), 5'd0, 3'b010, 5'd5, op_load));
        emit(store_instr(out_off, 5'd5, 5'd0));
        expect_out(32'h5a5);

        // taken branches skip the store right after them
        emit(imm_instr(12'd7, 5'd0, f3_addi, 5'd6, op_opimm));
        emit(imm_instr(12'd9, 5'd0, f3_addi, 5'd7, op_opimm));
        emit(branch_instr(13'd8, 5'd6, 5'd6, f3_beq));
        emit(store_instr(out_off, 5'd7, 5'd0));
        emit(branch_instr(13'd8, 5'd7, 5'd6, f3_bne));
        emit(store_instr(out_off, 5'd7, 5'd0));
        emit(branch_instr(13'd8, 5'd7, 5'd6, f3_beq));
        emit(store_instr(out_off, 5'd6, 5'd0));
        expect_out(32'd7);
        emit(branch_instr(13'd8, 5'd6, 5'd6, f3_bne));
        emit(store_instr(out_off, 5'd7, 5'd0));
        expect_out(32'd9);

        emit(upper_instr(20'habcde, 5'd8, op_lui));
        emit(store_instr(out_off, 5'd8, 5'd0));
        expect_out(32'habcd_e000);
        auipc_pc = prog_base + addr_t'(4 * prog.size());
        emit(upper_instr(20'h00012, 5'd9, op_auipc));
        emit(store_instr(out_off, 5'd9, 5'd0));
        expect_out(32'h0001_2000 + auipc_pc);

        emit(imm_instr(12'd55, 5'd0, f3_addi, 5'd0, op_opimm));
        emit(store_instr(out_off, 5'd0, 5'd0));
        expect_out(32'd0);

        // halt and then a store that must never run
        halt_pc = prog_base + addr_t'(4 * prog.size());
        emit(store_instr(halt_off, 5'd0, 5'd0));
        emit(store_instr(out_off, 5'd6, 5'd0));

        for (int k = 0; k < prog.size(); k++) begin
            mem[int'(prog_base[9:2]) + k] = prog[k];
        end
        timeout_limit = prog.size() * 8 + 100;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        wait (halt === 1'b1);
        // quiet window in which nothing may move after halt
        repeat (20) @(posedge clk);
        chk.finish_checks(32'h5a5, halt_pc);

        $display("errors: %0d value, %0d other; %0d of %0d outputs seen",
                 chk.value_errors, chk.other_errors, chk.outen_count, num_expected);
        if (chk.value_errors + chk.other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/core_cfg_pkg.sv
logic/rv_isa_pkg.sv
logic/regfile_if.sv
logic/instr_decoder.sv
logic/alu.sv
logic/register_file.sv
logic/core_control.sv
logic/core_top.sv
test/core_checker.sv
test/tb_core.sv
